// ==== source/cpuPkg.sv ====
package cpuPkg;

    // Datapath and storage sizes
    localparam int DATA_BITS      = 32;
    localparam int REG_ADDR_BITS  = 5;
    localparam int REG_COUNT      = 2 ** REG_ADDR_BITS;
    localparam int IMM_BITS       = 16;
    localparam int JUMP_BITS      = 26;
    localparam int IMEM_ADDR_BITS = 8;
    localparam int IMEM_WORDS     = 2 ** IMEM_ADDR_BITS;
    localparam int DMEM_ADDR_BITS = 8;
    localparam int DMEM_WORDS     = 2 ** DMEM_ADDR_BITS;

    // Instruction field positions
    localparam int OPCODE_BITS = 6;
    localparam int FUNCT_BITS  = 6;
    localparam int OPCODE_LSB  = 26;
    localparam int RS_LSB      = 21;
    localparam int RT_LSB      = 16;
    localparam int RD_LSB      = 11;
    localparam int FUNCT_LSB   = 0;

    // sll $0, $0, 0
    localparam logic [DATA_BITS-1:0] NOP_INSTR = '0;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeT;

    typedef enum logic [FUNCT_BITS-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functT;

    // ALU category chosen in decode
    typedef enum logic [1:0] {
        ALUOP_MEMADD = 2'b00,
        ALUOP_BRSUB  = 2'b01,
        ALUOP_RFUNCT = 2'b10,
        ALUOP_IMMOP  = 2'b11
    } aluOpT;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluCtrlT;

endpackage

// ==== source/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_rsAddr,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_rtAddr,
    input  logic                               i_wrEn,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_wrAddr,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_wrData,
    output logic [cpuPkg::DATA_BITS-1:0]       o_rsData,
    output logic [cpuPkg::DATA_BITS-1:0]       o_rtData
);

    logic [cpuPkg::DATA_BITS-1:0] regs [cpuPkg::REG_COUNT];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEn && i_wrAddr != '0) begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

    // Writeback data visible to decode in the same cycle
    assign o_rsData = (i_rsAddr == '0) ? '0 :
                      (i_wrEn && i_wrAddr == i_rsAddr) ? i_wrData : regs[i_rsAddr];
    assign o_rtData = (i_rtAddr == '0) ? '0 :
                      (i_wrEn && i_wrAddr == i_rtAddr) ? i_wrData : regs[i_rtAddr];

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_imemWe,
    input  logic [cpuPkg::IMEM_ADDR_BITS-1:0]   i_imemAddr,
    input  logic [cpuPkg::DATA_BITS-1:0]        i_imemData,
    input  logic                                i_branchTaken,
    input  logic [cpuPkg::DATA_BITS-1:0]        i_branchTarget,
    input  logic                                i_jumpTaken,
    input  logic [cpuPkg::DATA_BITS-1:0]        i_jumpTarget,
    output logic [cpuPkg::DATA_BITS-1:0]        o_ifidInstr,
    output logic [cpuPkg::DATA_BITS-1:0]        o_ifidPc4
);

    logic [cpuPkg::DATA_BITS-1:0] pc;
    logic [cpuPkg::DATA_BITS-1:0] pcPlus4;
    logic [cpuPkg::DATA_BITS-1:0] nextPc;
    logic [cpuPkg::DATA_BITS-1:0] imem [cpuPkg::IMEM_WORDS];

    assign pcPlus4 = pc + 4;

    // Branch from memory stage beats jump from decode
    always_comb begin
        if (i_branchTaken) begin
            nextPc = i_branchTarget;
        end else if (i_jumpTaken) begin
            nextPc = i_jumpTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // PC frozen while a program is loaded
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (!i_imemWe) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_imemWe) begin
            imem[i_imemAddr] <= i_imemData;
        end
    end

    ////////////////////////////////////////
    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (i_rst || i_imemWe) begin
            o_ifidInstr <= cpuPkg::NOP_INSTR;
        end else begin
            o_ifidInstr <= imem[pc[cpuPkg::IMEM_ADDR_BITS+1:2]];
        end
        o_ifidPc4 <= pcPlus4;
    end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_ifidInstr,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_ifidPc4,
    input  logic                               i_wbEn,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_wbReg,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_wbData,
    output logic                               o_jumpTaken,
    output logic [cpuPkg::DATA_BITS-1:0]       o_jumpTarget,
    output logic [cpuPkg::DATA_BITS-1:0]       o_idexPc4,
    output logic [cpuPkg::DATA_BITS-1:0]       o_idexRs,
    output logic [cpuPkg::DATA_BITS-1:0]       o_idexRt,
    output logic [cpuPkg::DATA_BITS-1:0]       o_idexImm,
    output logic [cpuPkg::REG_ADDR_BITS-1:0]   o_idexRtIdx,
    output logic [cpuPkg::REG_ADDR_BITS-1:0]   o_idexRdIdx,
    output logic [cpuPkg::FUNCT_BITS-1:0]      o_idexFunct,
    output logic [cpuPkg::OPCODE_BITS-1:0]     o_idexOpcode,
    output logic                               o_idexAluSrc,
    output cpuPkg::aluOpT                      o_idexAluOp,
    output logic                               o_idexRegDst,
    output logic                               o_idexBranch,
    output logic                               o_idexMemRead,
    output logic                               o_idexMemWrite,
    output logic                               o_idexMemToReg,
    output logic                               o_idexRegWrite
);

    cpuPkg::opcodeT                      opcode;
    cpuPkg::aluOpT                       aluOp;
    logic [cpuPkg::REG_ADDR_BITS-1:0]    rsIdx;
    logic [cpuPkg::REG_ADDR_BITS-1:0]    rtIdx;
    logic [cpuPkg::IMM_BITS-1:0]         imm16;
    logic [cpuPkg::DATA_BITS-1:0]        immExt;
    logic [cpuPkg::DATA_BITS-1:0]        rsData;
    logic [cpuPkg::DATA_BITS-1:0]        rtData;
    logic aluSrc;
    logic regDst;
    logic branch;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic zeroExt;

    assign opcode = cpuPkg::opcodeT'(i_ifidInstr[cpuPkg::OPCODE_LSB +: cpuPkg::OPCODE_BITS]);
    assign rsIdx  = i_ifidInstr[cpuPkg::RS_LSB +: cpuPkg::REG_ADDR_BITS];
    assign rtIdx  = i_ifidInstr[cpuPkg::RT_LSB +: cpuPkg::REG_ADDR_BITS];
    assign imm16  = i_ifidInstr[cpuPkg::IMM_BITS-1:0];

    ////////////////////////////////////////
    // Main control
    always_comb begin
        aluSrc      = 1'b0;
        aluOp       = cpuPkg::ALUOP_MEMADD;
        regDst      = 1'b0;
        branch      = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memToReg    = 1'b0;
        regWrite    = 1'b0;
        zeroExt     = 1'b0;
        o_jumpTaken = 1'b0;
        case (opcode)
            cpuPkg::OP_RTYPE: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluOp    = cpuPkg::ALUOP_RFUNCT;
            end
            cpuPkg::OP_ADDI, cpuPkg::OP_SLTI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = cpuPkg::ALUOP_IMMOP;
            end
            // Logical immediates take zero extension
            cpuPkg::OP_ANDI, cpuPkg::OP_ORI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                zeroExt  = 1'b1;
                aluOp    = cpuPkg::ALUOP_IMMOP;
            end
            cpuPkg::OP_LW: begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            cpuPkg::OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            cpuPkg::OP_BEQ: begin
                branch = 1'b1;
                aluOp  = cpuPkg::ALUOP_BRSUB;
            end
            cpuPkg::OP_J: o_jumpTaken = 1'b1;
            default: ;
        endcase
    end

    assign immExt = zeroExt ? {{(cpuPkg::DATA_BITS-cpuPkg::IMM_BITS){1'b0}}, imm16}
                            : {{(cpuPkg::DATA_BITS-cpuPkg::IMM_BITS){imm16[cpuPkg::IMM_BITS-1]}},
                               imm16};

    // Upper PC+4 bits with the word index
    assign o_jumpTarget = {i_ifidPc4[cpuPkg::DATA_BITS-1:cpuPkg::JUMP_BITS+2],
                           i_ifidInstr[cpuPkg::JUMP_BITS-1:0], 2'b00};

    regFile u_regFile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_rsAddr (rsIdx),
        .i_rtAddr (rtIdx),
        .i_wrEn   (i_wbEn),
        .i_wrAddr (i_wbReg),
        .i_wrData (i_wbData),
        .o_rsData (rsData),
        .o_rtData (rtData)
    );

    ////////////////////////////////////////
    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_idexAluSrc   <= 1'b0;
            o_idexAluOp    <= cpuPkg::ALUOP_MEMADD;
            o_idexRegDst   <= 1'b0;
            o_idexBranch   <= 1'b0;
            o_idexMemRead  <= 1'b0;
            o_idexMemWrite <= 1'b0;
            o_idexMemToReg <= 1'b0;
            o_idexRegWrite <= 1'b0;
        end else begin
            o_idexAluSrc   <= aluSrc;
            o_idexAluOp    <= aluOp;
            o_idexRegDst   <= regDst;
            o_idexBranch   <= branch;
            o_idexMemRead  <= memRead;
            o_idexMemWrite <= memWrite;
            o_idexMemToReg <= memToReg;
            o_idexRegWrite <= regWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        o_idexPc4    <= i_ifidPc4;
        o_idexRs     <= rsData;
        o_idexRt     <= rtData;
        o_idexImm    <= immExt;
        o_idexRtIdx  <= rtIdx;
        o_idexRdIdx  <= i_ifidInstr[cpuPkg::RD_LSB +: cpuPkg::REG_ADDR_BITS];
        o_idexFunct  <= i_ifidInstr[cpuPkg::FUNCT_LSB +: cpuPkg::FUNCT_BITS];
        o_idexOpcode <= opcode;
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_idexPc4,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_idexRs,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_idexRt,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_idexImm,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_idexRtIdx,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_idexRdIdx,
    input  logic [cpuPkg::FUNCT_BITS-1:0]      i_idexFunct,
    input  logic [cpuPkg::OPCODE_BITS-1:0]     i_idexOpcode,
    input  logic                               i_idexAluSrc,
    input  cpuPkg::aluOpT                      i_idexAluOp,
    input  logic                               i_idexRegDst,
    input  logic                               i_idexBranch,
    input  logic                               i_idexMemRead,
    input  logic                               i_idexMemWrite,
    input  logic                               i_idexMemToReg,
    input  logic                               i_idexRegWrite,
    output logic [cpuPkg::DATA_BITS-1:0]       o_exmemAlu,
    output logic                               o_exmemZero,
    output logic [cpuPkg::DATA_BITS-1:0]       o_exmemRtData,
    output logic [cpuPkg::REG_ADDR_BITS-1:0]   o_exmemDest,
    output logic [cpuPkg::DATA_BITS-1:0]       o_exmemBranchTarget,
    output logic                               o_exmemBranch,
    output logic                               o_exmemMemRead,
    output logic                               o_exmemMemWrite,
    output logic                               o_exmemMemToReg,
    output logic                               o_exmemRegWrite
);

    cpuPkg::functT                 funct;
    cpuPkg::opcodeT                opcode;
    cpuPkg::aluCtrlT               aluCtrl;
    logic [cpuPkg::DATA_BITS-1:0]  operandB;
    logic [cpuPkg::DATA_BITS-1:0]  aluResult;

    assign funct  = cpuPkg::functT'(i_idexFunct);
    assign opcode = cpuPkg::opcodeT'(i_idexOpcode);

    ////////////////////////////////////////
    // ALU control
    always_comb begin
        aluCtrl = cpuPkg::ALU_ADD;
        case (i_idexAluOp)
            cpuPkg::ALUOP_BRSUB: aluCtrl = cpuPkg::ALU_SUB;
            cpuPkg::ALUOP_RFUNCT: begin
                case (funct)
                    cpuPkg::FN_SUB: aluCtrl = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND: aluCtrl = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:  aluCtrl = cpuPkg::ALU_OR;
                    cpuPkg::FN_SLT: aluCtrl = cpuPkg::ALU_SLT;
                    default:        aluCtrl = cpuPkg::ALU_ADD;
                endcase
            end
            // Immediate forms follow the opcode
            cpuPkg::ALUOP_IMMOP: begin
                case (opcode)
                    cpuPkg::OP_SLTI: aluCtrl = cpuPkg::ALU_SLT;
                    cpuPkg::OP_ANDI: aluCtrl = cpuPkg::ALU_AND;
                    cpuPkg::OP_ORI:  aluCtrl = cpuPkg::ALU_OR;
                    default:         aluCtrl = cpuPkg::ALU_ADD;
                endcase
            end
            default: aluCtrl = cpuPkg::ALU_ADD;
        endcase
    end

    assign operandB = i_idexAluSrc ? i_idexImm : i_idexRt;

    always_comb begin
        case (aluCtrl)
            cpuPkg::ALU_AND: aluResult = i_idexRs & operandB;
            cpuPkg::ALU_OR:  aluResult = i_idexRs | operandB;
            cpuPkg::ALU_SUB: aluResult = i_idexRs - operandB;
            // Signed compare
            cpuPkg::ALU_SLT: aluResult = {{(cpuPkg::DATA_BITS-1){1'b0}},
                                          $signed(i_idexRs) < $signed(operandB)};
            default:         aluResult = i_idexRs + operandB;
        endcase
    end

    ////////////////////////////////////////
    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_exmemBranch   <= 1'b0;
            o_exmemMemRead  <= 1'b0;
            o_exmemMemWrite <= 1'b0;
            o_exmemMemToReg <= 1'b0;
            o_exmemRegWrite <= 1'b0;
        end else begin
            o_exmemBranch   <= i_idexBranch;
            o_exmemMemRead  <= i_idexMemRead;
            o_exmemMemWrite <= i_idexMemWrite;
            o_exmemMemToReg <= i_idexMemToReg;
            o_exmemRegWrite <= i_idexRegWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        o_exmemAlu          <= aluResult;
        o_exmemZero         <= (aluResult == '0);
        o_exmemRtData       <= i_idexRt;
        o_exmemDest         <= i_idexRegDst ? i_idexRdIdx : i_idexRtIdx;
        o_exmemBranchTarget <= i_idexPc4 + {i_idexImm[cpuPkg::DATA_BITS-3:0], 2'b00};
    end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_exmemAlu,
    input  logic                               i_exmemZero,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_exmemRtData,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_exmemDest,
    input  logic                               i_exmemBranch,
    input  logic                               i_exmemMemRead,
    input  logic                               i_exmemMemWrite,
    input  logic                               i_exmemMemToReg,
    input  logic                               i_exmemRegWrite,
    output logic                               o_branchTaken,
    output logic                               o_wbEn,
    output logic [cpuPkg::REG_ADDR_BITS-1:0]   o_wbReg,
    output logic [cpuPkg::DATA_BITS-1:0]       o_wbData,
    output logic                               o_wbValid
);

    logic [cpuPkg::DATA_BITS-1:0]       dmem [cpuPkg::DMEM_WORDS];
    logic [cpuPkg::DMEM_ADDR_BITS-1:0]  wordAddr;
    logic [cpuPkg::DATA_BITS-1:0]       readData;
    logic [cpuPkg::DATA_BITS-1:0]       wbAlu;
    logic [cpuPkg::DATA_BITS-1:0]       wbMem;
    logic                               wbMemToReg;

    // Byte address to word index
    assign wordAddr      = i_exmemAlu[cpuPkg::DMEM_ADDR_BITS+1:2];
    assign readData      = i_exmemMemRead ? dmem[wordAddr] : '0;
    assign o_branchTaken = i_exmemBranch && i_exmemZero;

    always_ff @(posedge i_clk) begin
        if (i_exmemMemWrite) begin
            dmem[wordAddr] <= i_exmemRtData;
        end
    end

    ////////////////////////////////////////
    // MEM/WB register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wbEn     <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            o_wbEn     <= i_exmemRegWrite;
            wbMemToReg <= i_exmemMemToReg;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wbReg <= i_exmemDest;
        wbAlu   <= i_exmemAlu;
        wbMem   <= readData;
    end

    assign o_wbData  = wbMemToReg ? wbMem : wbAlu;
    // Writes to register 0 stay off the trace
    assign o_wbValid = o_wbEn && (o_wbReg != '0);

endmodule

// ==== source/mipsPipeline.sv ====
`timescale 1ns/100ps

module mipsPipeline (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_imemWe,
    input  logic [cpuPkg::IMEM_ADDR_BITS-1:0]   i_imemAddr,
    input  logic [cpuPkg::DATA_BITS-1:0]        i_imemData,
    output logic                                o_wbValid,
    output logic [cpuPkg::REG_ADDR_BITS-1:0]    o_wbReg,
    output logic [cpuPkg::DATA_BITS-1:0]        o_wbData
);

    // Fetch and decode
    logic [cpuPkg::DATA_BITS-1:0]       ifidInstr;
    logic [cpuPkg::DATA_BITS-1:0]       ifidPc4;
    logic                               jumpTaken;
    logic [cpuPkg::DATA_BITS-1:0]       jumpTarget;

    // ID/EX
    logic [cpuPkg::DATA_BITS-1:0]       idexPc4;
    logic [cpuPkg::DATA_BITS-1:0]       idexRs;
    logic [cpuPkg::DATA_BITS-1:0]       idexRt;
    logic [cpuPkg::DATA_BITS-1:0]       idexImm;
    logic [cpuPkg::REG_ADDR_BITS-1:0]   idexRtIdx;
    logic [cpuPkg::REG_ADDR_BITS-1:0]   idexRdIdx;
    logic [cpuPkg::FUNCT_BITS-1:0]      idexFunct;
    logic [cpuPkg::OPCODE_BITS-1:0]     idexOpcode;
    cpuPkg::aluOpT                      idexAluOp;
    logic idexAluSrc;
    logic idexRegDst;
    logic idexBranch;
    logic idexMemRead;
    logic idexMemWrite;
    logic idexMemToReg;
    logic idexRegWrite;

    // EX/MEM
    logic [cpuPkg::DATA_BITS-1:0]       exmemAlu;
    logic [cpuPkg::DATA_BITS-1:0]       exmemRtData;
    logic [cpuPkg::REG_ADDR_BITS-1:0]   exmemDest;
    logic [cpuPkg::DATA_BITS-1:0]       exmemBranchTarget;
    logic exmemZero;
    logic exmemBranch;
    logic exmemMemRead;
    logic exmemMemWrite;
    logic exmemMemToReg;
    logic exmemRegWrite;

    // Memory and writeback
    logic branchTaken;
    logic wbEn;
    logic [cpuPkg::REG_ADDR_BITS-1:0]   wbReg;

    assign o_wbReg = wbReg;

    fetchStage u_fetchStage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_imemWe       (i_imemWe),
        .i_imemAddr     (i_imemAddr),
        .i_imemData     (i_imemData),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (exmemBranchTarget),
        .i_jumpTaken    (jumpTaken),
        .i_jumpTarget   (jumpTarget),
        .o_ifidInstr    (ifidInstr),
        .o_ifidPc4      (ifidPc4)
    );

    decodeStage u_decodeStage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_ifidInstr    (ifidInstr),
        .i_ifidPc4      (ifidPc4),
        .i_wbEn         (wbEn),
        .i_wbReg        (wbReg),
        .i_wbData       (o_wbData),
        .o_jumpTaken    (jumpTaken),
        .o_jumpTarget   (jumpTarget),
        .o_idexPc4      (idexPc4),
        .o_idexRs       (idexRs),
        .o_idexRt       (idexRt),
        .o_idexImm      (idexImm),
        .o_idexRtIdx    (idexRtIdx),
        .o_idexRdIdx    (idexRdIdx),
        .o_idexFunct    (idexFunct),
        .o_idexOpcode   (idexOpcode),
        .o_idexAluSrc   (idexAluSrc),
        .o_idexAluOp    (idexAluOp),
        .o_idexRegDst   (idexRegDst),
        .o_idexBranch   (idexBranch),
        .o_idexMemRead  (idexMemRead),
        .o_idexMemWrite (idexMemWrite),
        .o_idexMemToReg (idexMemToReg),
        .o_idexRegWrite (idexRegWrite)
    );

    executeStage u_executeStage (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_idexPc4           (idexPc4),
        .i_idexRs            (idexRs),
        .i_idexRt            (idexRt),
        .i_idexImm           (idexImm),
        .i_idexRtIdx         (idexRtIdx),
        .i_idexRdIdx         (idexRdIdx),
        .i_idexFunct         (idexFunct),
        .i_idexOpcode        (idexOpcode),
        .i_idexAluSrc        (idexAluSrc),
        .i_idexAluOp         (idexAluOp),
        .i_idexRegDst        (idexRegDst),
        .i_idexBranch        (idexBranch),
        .i_idexMemRead       (idexMemRead),
        .i_idexMemWrite      (idexMemWrite),
        .i_idexMemToReg      (idexMemToReg),
        .i_idexRegWrite      (idexRegWrite),
        .o_exmemAlu          (exmemAlu),
        .o_exmemZero         (exmemZero),
        .o_exmemRtData       (exmemRtData),
        .o_exmemDest         (exmemDest),
        .o_exmemBranchTarget (exmemBranchTarget),
        .o_exmemBranch       (exmemBranch),
        .o_exmemMemRead      (exmemMemRead),
        .o_exmemMemWrite     (exmemMemWrite),
        .o_exmemMemToReg     (exmemMemToReg),
        .o_exmemRegWrite     (exmemRegWrite)
    );

    memoryStage u_memoryStage (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_exmemAlu      (exmemAlu),
        .i_exmemZero     (exmemZero),
        .i_exmemRtData   (exmemRtData),
        .i_exmemDest     (exmemDest),
        .i_exmemBranch   (exmemBranch),
        .i_exmemMemRead  (exmemMemRead),
        .i_exmemMemWrite (exmemMemWrite),
        .i_exmemMemToReg (exmemMemToReg),
        .i_exmemRegWrite (exmemRegWrite),
        .o_branchTaken   (branchTaken),
        .o_wbEn          (wbEn),
        .o_wbReg         (wbReg),
        .o_wbData        (o_wbData),
        .o_wbValid       (o_wbValid)
    );

endmodule

// ==== sim/mipsPipeline_asserts.sv ====
`timescale 1ns/100ps

module mipsPipeline_asserts (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_imemWe,
    input  logic                               i_wbValid,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_wbReg,
    input  logic                               i_exmemRegWrite,
    input  logic [cpuPkg::REG_ADDR_BITS-1:0]   i_exmemDest,
    input  logic [cpuPkg::DATA_BITS-1:0]       i_pc
);

    // Register 0 writes leaving the memory stage never show on the trace
    zeroDestOffTrace: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_exmemRegWrite && i_exmemDest == '0) |=> !i_wbValid)
        else $error("o_wbValid high for a write to register zero");

    wbValidKnown: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(i_wbValid))
        else $error("o_wbValid unknown after reset");

    // Program load freezes the PC
    pcHeldOnLoad: assert property (@(posedge i_clk) disable iff (i_rst)
        i_imemWe |=> $stable(i_pc))
        else $error("PC moved during an instruction memory write");

endmodule

bind mipsPipeline mipsPipeline_asserts u_asserts (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_imemWe        (i_imemWe),
    .i_wbValid       (o_wbValid),
    .i_wbReg         (o_wbReg),
    .i_exmemRegWrite (exmemRegWrite),
    .i_exmemDest     (exmemDest),
    .i_pc            (u_fetchStage.pc)
);

// ==== sim/mipsPipelineTb.sv ====
`timescale 1ns/100ps

module mipsPipelineTb;

    logic                                clk;
    logic                                rst;
    logic                                imemWe;
    logic [cpuPkg::IMEM_ADDR_BITS-1:0]   imemAddr;
    logic [cpuPkg::DATA_BITS-1:0]        imemData;
    logic                                wbValid;
    logic [cpuPkg::REG_ADDR_BITS-1:0]    wbReg;
    logic [cpuPkg::DATA_BITS-1:0]        wbData;

    // Program image and expected writeback trace
    logic [cpuPkg::IMEM_ADDR_BITS-1:0]   loadAddrQ [$];
    logic [cpuPkg::DATA_BITS-1:0]        loadWordQ [$];
    logic [cpuPkg::REG_ADDR_BITS-1:0]    expRegQ [$];
    logic [cpuPkg::DATA_BITS-1:0]        expDataQ [$];

    int valueErrors;
    int countErrors;
    int wbCount;
    int cycleCount;
    int cycleLimit;
    bit runActive;
    bit fileOk;

    mipsPipeline i_mipsPipeline (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_imemWe   (imemWe),
        .i_imemAddr (imemAddr),
        .i_imemData (imemData),
        .o_wbValid  (wbValid),
        .o_wbReg    (wbReg),
        .o_wbData   (wbData)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Helpers
    task automatic readProgramFile();
        int          fd;
        int          fields;
        string       line;
        string       kind;
        logic [31:0] first;
        logic [31:0] second;
        fd = $fopen("sim/testdata_prog.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/testdata_prog.txt");
            countErrors++;
            fileOk = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Blank lines and comment lines skipped
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %h", kind, first, second);
                    if (fields != 3) begin
                        $display("Malformed line in program file: %s", line);
                        countErrors++;
                    end else if (kind == "I") begin
                        loadAddrQ.push_back(first[cpuPkg::IMEM_ADDR_BITS-1:0]);
                        loadWordQ.push_back(second);
                    end else if (kind == "W") begin
                        expRegQ.push_back(first[cpuPkg::REG_ADDR_BITS-1:0]);
                        expDataQ.push_back(second);
                    end else begin
                        $display("Unknown line kind %s in program file", kind);
                        countErrors++;
                    end
                end
            end
            $fclose(fd);
            fileOk = (loadAddrQ.size() > 0);
            if (!fileOk) begin
                $display("Program file holds no instruction words");
                countErrors++;
            end
        end
    endtask

    // One word per cycle, PC held by the DUT meanwhile
    task automatic loadProgram();
        for (int k = 0; k < loadAddrQ.size(); k++) begin
            imemWe   = 1'b1;
            imemAddr = loadAddrQ[k];
            imemData = loadWordQ[k];
            @(posedge clk);
            #10;
        end
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
    endtask

    task automatic printSummaryAndStop();
        $display("Summary: %0d value errors, %0d count errors, %0d of %0d writebacks seen",
                 valueErrors, countErrors, wbCount, expRegQ.size());
        if (valueErrors == 0 && countErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Writeback trace monitor
    always @(negedge clk) begin
        if (!rst && wbValid) begin
            if (wbCount < expRegQ.size()) begin
                if (wbReg !== expRegQ[wbCount]) begin
                    $display("[FAIL] %0t o_wbReg expected %0d got %0d",
                             $time, expRegQ[wbCount], wbReg);
                    valueErrors++;
                end
                if (wbData !== expDataQ[wbCount]) begin
                    $display("[FAIL] %0t o_wbData expected %08h got %08h",
                             $time, expDataQ[wbCount], wbData);
                    valueErrors++;
                end
            end else begin
                $display("Extra writeback to register %0d after all %0d expected ones",
                         wbReg, expRegQ.size());
                countErrors++;
            end
            wbCount++;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        if (runActive) begin
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout after %0d cycles, only %0d of %0d writebacks seen",
                         cycleCount, wbCount, expRegQ.size());
                countErrors++;
                printSummaryAndStop();
            end
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst         = 1'b1;
        imemWe      = 1'b0;
        imemAddr    = '0;
        imemData    = '0;
        valueErrors = 0;
        countErrors = 0;
        wbCount     = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        runActive   = 1'b0;
        fileOk      = 1'b0;

        // Reset for 8 cycles
        repeat (8) @(posedge clk);
        #10;
        readProgramFile();
        rst = 1'b0;
        if (!fileOk) begin
            printSummaryAndStop();
        end else begin
            cycleLimit = 4 * (loadAddrQ.size() + 8);
            runActive  = 1'b1;
            loadProgram();
            while (wbCount < expRegQ.size()) begin
                @(posedge clk);
            end
            // Program parks in a self-jump, so nothing more should arrive
            repeat (8) @(posedge clk);
            printSummaryAndStop();
        end
    end

endmodule

// ==== sim/testdata_prog.txt ====
# I <imem word address> <instruction word>   program image, hex
# W <register> <value>                       expected writebacks in order, hex
I 00 2001FFFB  # addi r1, r0, -5
I 01 34028001  # ori  r2, r0, 0x8001
I 02 2803FFFF  # slti r3, r0, -1
I 03 20040123  # addi r4, r0, 0x123
I 04 3025FF0F  # andi r5, r1, 0xff0f
I 05 28260000  # slti r6, r1, 0
I 06 00223820  # add  r7, r1, r2
I 07 00444022  # sub  r8, r2, r4
I 08 00224824  # and  r9, r1, r2
I 09 00825025  # or   r10, r4, r2
I 0A 0024582A  # slt  r11, r1, r4
I 0B 0081602A  # slt  r12, r4, r1
I 0C AC070010  # sw   r7, 0x10(r0)
I 0D 20000055  # addi r0, r0, 0x55
I 0E AC080014  # sw   r8, 0x14(r0)
I 0F 00220020  # add  r0, r1, r2
I 10 8C0D0010  # lw   r13, 0x10(r0)
I 11 8C0E0014  # lw   r14, 0x14(r0)
I 12 10220005  # beq  r1, r2 not taken
I 13 200F0001  # addi r15, r0, 1
I 14 20100002  # addi r16, r0, 2
I 15 20110003  # addi r17, r0, 3
I 16 11A70006  # beq  r13, r7 taken to 0x1d
I 17 20120004  # addi r18, r0, 4
I 18 20130005  # addi r19, r0, 5
I 19 20140006  # addi r20, r0, 6
I 1A 20150007  # addi r21 skipped
I 1B 20160008  # addi r22 skipped
I 1C 20170009  # addi r23 skipped
I 1D 2018000A  # addi r24, r0, 10
I 1E 08000021  # j    0x21
I 1F 2019000B  # addi r25, r0, 11
I 20 201A000C  # addi r26 skipped
I 21 201B000D  # addi r27, r0, 13
I 22 08000022  # j    0x22 self loop
I 23 00000000  # nop
W 01 FFFFFFFB
W 02 00008001
W 03 00000000
W 04 00000123
W 05 0000FF0B
W 06 00000001
W 07 00007FFC
W 08 00007EDE
W 09 00008001
W 0A 00008123
W 0B 00000001
W 0C 00000000
W 0D 00007FFC
W 0E 00007EDE
W 0F 00000001
W 10 00000002
W 11 00000003
W 12 00000004
W 13 00000005
W 14 00000006
W 18 0000000A
W 19 0000000B
W 1B 0000000D

// ==== vlog.f ====
source/cpuPkg.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsPipeline.sv
sim/mipsPipeline_asserts.sv
sim/mipsPipelineTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module mipsPipelineTb -o simv

if ! ./obj_dir/simv > sim.log 2>&1; then
    cat sim.log
    exit 1
fi
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
